//--- design/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

////////////////////
// clocking
////////////////////

// system clock in hz
`define UART_CLK_HZ 50_000_000

// line rate used for the reset divisor
`define UART_BAUD 115_200

// clocks per bit after reset, 434 at 50 mhz
`define UART_DEFAULT_DIV (`UART_CLK_HZ / `UART_BAUD)

////////////////////
// widths
////////////////////

// bit period counter and divisor register
`define UART_DIV_W 16

// good byte and framing error counters
`define UART_CNT_W 8

`endif

//--- design/uart_pkg.sv
`include "uart_config.svh"

package uart_pkg;

	////////////////////
	// serial payload
	////////////////////

	// one character on the line
	typedef logic [7:0] data_byte_t;

	// bit period in clocks
	typedef logic [`UART_DIV_W-1:0] bit_div_t;

	// receiver result, byte plus stop bit check
	typedef struct packed {
		data_byte_t data;
		// stop bit sampled as 0
		logic       frame_err;
	} rx_frame_t;

	////////////////////
	// state machines
	////////////////////

	// receiver, start qualify then 8 data then stop
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_t;

	// transmitter, one state per bit group
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_t;

endpackage

//--- design/uart_csr_pkg.sv
`include "uart_config.svh"

package uart_csr_pkg;

	////////////////////
	// register map
	////////////////////

	// host addresses
	typedef enum logic [1:0] {
		// divisor, read/write
		CSR_DIV        = 2'd0,
		// bit 0 is echo enable
		CSR_CTRL       = 2'd1,
		// good bytes, write clears
		CSR_RX_COUNT   = 2'd2,
		// framing errors, write clears
		CSR_FERR_COUNT = 2'd3
	} csr_addr_t;

	// saturating event counter
	typedef logic [`UART_CNT_W-1:0] count_t;

	// control fields fanned out to rx and tx
	typedef struct packed {
		uart_pkg::bit_div_t div;
		logic               echo_en;
	} csr_ctrl_t;

	// one cycle event strobes from the receiver side
	typedef struct packed {
		logic good_byte;
		logic frame_err;
	} csr_event_t;

endpackage

//--- design/uart_rx.sv
module uart_rx (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    rx,
	input  uart_csr_pkg::csr_ctrl_t ctrl,
	output logic                    rx_valid,
	output uart_pkg::rx_frame_t     rx_frame
);

	// synchronizer and edge detect
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_fall;

	// bit timing
	uart_pkg::rx_state_t  state;
	uart_pkg::bit_div_t   cnt;
	uart_pkg::bit_div_t   bit_last;
	uart_pkg::bit_div_t   half_last;
	logic [2:0]           bit_idx;
	uart_pkg::data_byte_t shift;

	// divisor sampled live, so a change hits the next bit boundary
	assign bit_last  = ctrl.div - uart_pkg::bit_div_t'(1);
	assign half_last = (ctrl.div >> 1) - uart_pkg::bit_div_t'(1);
	assign start_fall = rx_prev & ~rx_sync;

	////////////////////
	// input sync
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// line idles high
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	////////////////////
	// frame FSM
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= uart_pkg::RX_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE: begin
					// only a real fall starts a frame, a low stop bit does not
					cnt <= '0;
					if (start_fall) begin
						state <= uart_pkg::RX_START;
					end
				end
				uart_pkg::RX_START: begin
					if (cnt == half_last) begin
						cnt <= '0;
						bit_idx <= '0;
						// still low at mid-bit, else a glitch
						state <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end else begin
						cnt <= cnt + uart_pkg::bit_div_t'(1);
					end
				end
				uart_pkg::RX_DATA: begin
					if (cnt == bit_last) begin
						cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= uart_pkg::RX_STOP;
						end
					end else begin
						cnt <= cnt + uart_pkg::bit_div_t'(1);
					end
				end
				uart_pkg::RX_STOP: begin
					if (cnt == bit_last) begin
						// report at mid stop bit, ready again at once
						cnt <= '0;
						rx_valid <= 1'b1;
						state <= uart_pkg::RX_IDLE;
					end else begin
						cnt <= cnt + uart_pkg::bit_div_t'(1);
					end
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// payload, lsb arrives first
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && cnt == bit_last) begin
			shift <= {rx_sync, shift[7:1]};
		end
		if (state == uart_pkg::RX_STOP && cnt == bit_last) begin
			rx_frame.data      <= shift;
			rx_frame.frame_err <= ~rx_sync;
		end
	end

endmodule

//--- design/uart_tx.sv
module uart_tx (
	input  logic                    clk,
	input  logic                    rst_n,
	input  uart_csr_pkg::csr_ctrl_t ctrl,
	input  logic                    tx_start,
	input  uart_pkg::data_byte_t    tx_data,
	output logic                    tx,
	output logic                    busy
);

	uart_pkg::tx_state_t  state;
	uart_pkg::bit_div_t   cnt;
	uart_pkg::bit_div_t   bit_last;
	logic                 bit_end;
	logic [2:0]           bit_idx;
	uart_pkg::data_byte_t shift;

	assign bit_last = ctrl.div - uart_pkg::bit_div_t'(1);
	assign bit_end  = (cnt == bit_last);

	// high for start, 8 data and stop, 10 bit periods
	assign busy = (state != uart_pkg::TX_IDLE);

	////////////////////
	// frame FSM
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= uart_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			// per-bit counter, restarts at each boundary
			if (state == uart_pkg::TX_IDLE || bit_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + uart_pkg::bit_div_t'(1);
			end
			case (state)
				uart_pkg::TX_IDLE: begin
					// start strobe while busy never reaches here
					if (tx_start) begin
						tx <= 1'b0;
						state <= uart_pkg::TX_START;
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						tx <= shift[0];
						bit_idx <= '0;
						state <= uart_pkg::TX_DATA;
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							// stop bit
							tx <= 1'b1;
							state <= uart_pkg::TX_STOP;
						end else begin
							tx <= shift[0];
							bit_idx <= bit_idx + 3'd1;
						end
					end
				end
				uart_pkg::TX_STOP: begin
					if (bit_end) begin
						state <= uart_pkg::TX_IDLE;
					end
				end
				default: state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// byte latch and lsb-first shift
	always_ff @(posedge clk) begin
		if (state == uart_pkg::TX_IDLE && tx_start) begin
			shift <= tx_data;
		end else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
			shift <= shift >> 1;
		end
	end

endmodule

//--- design/uart_csr.sv
`include "uart_config.svh"

module uart_csr (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cfg_we,
	input  uart_csr_pkg::csr_addr_t  cfg_addr,
	input  logic [`UART_DIV_W-1:0]   cfg_wdata,
	output logic [`UART_DIV_W-1:0]   cfg_rdata,
	input  uart_csr_pkg::csr_event_t events,
	output uart_csr_pkg::csr_ctrl_t  ctrl
);

	uart_csr_pkg::count_t rx_cnt;
	uart_csr_pkg::count_t ferr_cnt;
	logic                 clr_rx;
	logic                 clr_ferr;

	// counter clears by host write
	assign clr_rx   = cfg_we && (cfg_addr == uart_csr_pkg::CSR_RX_COUNT);
	assign clr_ferr = cfg_we && (cfg_addr == uart_csr_pkg::CSR_FERR_COUNT);

	////////////////////
	// control regs
	////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.div     <= uart_pkg::bit_div_t'(`UART_DEFAULT_DIV);
			ctrl.echo_en <= 1'b1;
		end else if (cfg_we) begin
			case (cfg_addr)
				uart_csr_pkg::CSR_DIV:  ctrl.div <= cfg_wdata;
				uart_csr_pkg::CSR_CTRL: ctrl.echo_en <= cfg_wdata[0];
				default: ;
			endcase
		end
	end

	////////////////////
	// event counters
	////////////////////

	// clear beats a same-cycle event, counts stop at all ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_cnt   <= '0;
			ferr_cnt <= '0;
		end else begin
			if (clr_rx) begin
				rx_cnt <= '0;
			end else if (events.good_byte && rx_cnt != '1) begin
				rx_cnt <= rx_cnt + uart_csr_pkg::count_t'(1);
			end
			if (clr_ferr) begin
				ferr_cnt <= '0;
			end else if (events.frame_err && ferr_cnt != '1) begin
				ferr_cnt <= ferr_cnt + uart_csr_pkg::count_t'(1);
			end
		end
	end

	// read mux, narrow fields zero-extended
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			uart_csr_pkg::CSR_DIV:        cfg_rdata = ctrl.div;
			uart_csr_pkg::CSR_CTRL:       cfg_rdata[0] = ctrl.echo_en;
			uart_csr_pkg::CSR_RX_COUNT:   cfg_rdata[`UART_CNT_W-1:0] = rx_cnt;
			uart_csr_pkg::CSR_FERR_COUNT: cfg_rdata[`UART_CNT_W-1:0] = ferr_cnt;
			default:                      cfg_rdata = '0;
		endcase
	end

endmodule

//--- design/uart_echo_top.sv
`include "uart_config.svh"

module uart_echo_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    rx,
	output logic                    tx,
	input  logic                    cfg_we,
	input  uart_csr_pkg::csr_addr_t cfg_addr,
	input  logic [`UART_DIV_W-1:0]  cfg_wdata,
	output logic [`UART_DIV_W-1:0]  cfg_rdata
);

	uart_csr_pkg::csr_ctrl_t  ctrl;
	uart_csr_pkg::csr_event_t events;
	uart_pkg::rx_frame_t      rx_frame;
	logic                     rx_valid;
	logic                     tx_start;
	// transmitter activity, watched by the bound checks
	logic                     busy;

	////////////////////
	// echo gating
	////////////////////

	// good frames only, and only with echo on
	assign tx_start = rx_valid & ~rx_frame.frame_err & ctrl.echo_en;

	// counter strobes
	assign events.good_byte = rx_valid & ~rx_frame.frame_err;
	assign events.frame_err = rx_valid & rx_frame.frame_err;

	uart_rx uart_rx_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx       (rx),
		.ctrl     (ctrl),
		.rx_valid (rx_valid),
		.rx_frame (rx_frame)
	);

	uart_tx uart_tx_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl),
		.tx_start (tx_start),
		.tx_data  (rx_frame.data),
		.tx       (tx),
		.busy     (busy)
	);

	uart_csr uart_csr_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.events    (events),
		.ctrl      (ctrl)
	);

endmodule

//--- tb/uart_echo_assertions.sv
module uart_echo_assertions (
	input logic                clk,
	input logic                rst_n,
	input logic                tx,
	input logic                busy,
	input logic                rx_valid,
	input logic                tx_start,
	input uart_pkg::rx_frame_t rx_frame
);
	timeunit 1ns;
	timeprecision 1ps;

	// idle transmitter holds the line high
	tx_idle_high: assert property (
		@(posedge clk) disable iff (!rst_n) !busy |-> tx
	) else $error("tx low while the transmitter is idle");

	// receiver reports a frame for one cycle only
	rx_valid_pulse: assert property (
		@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
	) else $error("rx_valid high for two cycles in a row");

	// bad stop bit never starts the transmitter
	no_echo_on_ferr: assert property (
		@(posedge clk) disable iff (!rst_n) rx_valid && rx_frame.frame_err && !busy |=> !busy
	) else $error("transmitter started on a frame with frame_err set");

	// echo start bit one clock after the strobe
	start_bit_next: assert property (
		@(posedge clk) disable iff (!rst_n) tx_start && !busy |=> busy && !tx
	) else $error("tx did not drop low the cycle after tx_start");

endmodule

//--- tb/uart_echo_checker.sv
`include "uart_config.svh"

module uart_echo_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   tx,
	input  logic [`UART_DIV_W-1:0] cfg_rdata,
	input  logic                   go,
	input  int                     idx,
	input  logic                   is_send,
	input  logic                   is_read,
	input  logic                   exp_valid,
	input  logic [`UART_DIV_W-1:0] expected,
	input  int                     div,
	output logic                   done,
	output int                     fail_count,
	output int                     test_count
);
	timeunit 1ns;
	timeprecision 1ps;

	task automatic tally(input logic ok);
		test_count++;
		if (!ok) begin
			fail_count++;
		end
	endtask

	////////////////////
	// tx decoder
	////////////////////

	// fall, then mid start bit, then one period per bit
	task automatic check_echo();
		int         waited;
		int         i;
		logic [7:0] got;
		logic       ok;
		waited = 0;
		got = '0;
		ok = 1'b1;
		while (tx !== 1'b0 && waited < 12 * div) begin
			@(negedge clk);
			waited++;
		end
		if (tx !== 1'b0) begin
			$display("test %0d: no echo started on tx within 12 bit periods", idx);
			ok = 1'b0;
		end else begin
			repeat (div / 2) @(negedge clk);
			if (tx !== 1'b0) begin
				$display("test %0d: echo start bit was not low at mid-bit", idx);
				ok = 1'b0;
			end
			for (i = 0; i < 8; i++) begin
				repeat (div) @(negedge clk);
				got[i] = tx;
			end
			repeat (div) @(negedge clk);
			if (tx !== 1'b1) begin
				$display("test %0d: echo stop bit was low", idx);
				ok = 1'b0;
			end
			if (got !== expected[7:0]) begin
				$display("** Error tx_byte: expected 0x%02h, actual 0x%02h", expected[7:0], got);
				ok = 1'b0;
			end
		end
		@(posedge clk);
		$display("test %0d send 0x%02h with echo: %s", idx, expected[7:0], ok ? "pass" : "fail");
		tally(ok);
	endtask

	// dropped or gated byte, line must stay high
	task automatic check_silence();
		logic ok;
		ok = 1'b1;
		repeat (12 * div) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				ok = 1'b0;
			end
		end
		if (!ok) begin
			$display("test %0d: tx fell although no echo was expected", idx);
		end
		@(posedge clk);
		$display("test %0d send without echo: %s", idx, ok ? "pass" : "fail");
		tally(ok);
	endtask

	////////////////////
	// register side
	////////////////////

	// address was set half a cycle earlier, read is combinational
	task automatic check_read();
		logic ok;
		ok = 1'b1;
		@(negedge clk);
		if (cfg_rdata !== expected) begin
			$display("** Error cfg_rdata: expected 0x%04h, actual 0x%04h", expected, cfg_rdata);
			ok = 1'b0;
		end
		if (tx !== 1'b1) begin
			$display("test %0d: tx was not idle during a register read", idx);
			ok = 1'b0;
		end
		@(posedge clk);
		$display("test %0d read: %s", idx, ok ? "pass" : "fail");
		tally(ok);
	endtask

	// write lands on the next edge, then the read mux shows it
	task automatic check_write();
		logic ok;
		ok = 1'b1;
		repeat (2) @(negedge clk);
		if (cfg_rdata !== expected) begin
			$display("** Error cfg_rdata: expected 0x%04h, actual 0x%04h", expected, cfg_rdata);
			ok = 1'b0;
		end
		@(posedge clk);
		$display("test %0d write: %s", idx, ok ? "pass" : "fail");
		tally(ok);
	endtask

	initial begin
		done = 1'b1;
		fail_count = 0;
		test_count = 0;
		forever begin
			@(posedge clk);
			if (go && rst_n) begin
				done = 1'b0;
				if (is_send && exp_valid) begin
					check_echo();
				end else if (is_send) begin
					check_silence();
				end else if (is_read) begin
					check_read();
				end else begin
					check_write();
				end
				done = 1'b1;
			end
		end
	end

endmodule

//--- tb/tb_uart_echo.sv
`include "uart_config.svh"

module tb_uart_echo;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DW = `UART_DIV_W;

	typedef logic [DW-1:0] word_t;

	// what one table row asks for
	typedef enum logic [1:0] {
		SEND     = 2'd0,
		SEND_BAD = 2'd1,
		WRITE    = 2'd2,
		READ     = 2'd3
	} kind_t;

	// one row, echo, read or readback value in expected
	typedef struct packed {
		kind_t                   kind;
		uart_csr_pkg::csr_addr_t addr;
		word_t                   data;
		logic                    exp_valid;
		word_t                   expected;
	} entry_t;

	logic                    clk;
	logic                    rst_n;
	logic                    rx;
	logic                    tx;
	logic                    cfg_we;
	uart_csr_pkg::csr_addr_t cfg_addr;
	word_t                   cfg_wdata;
	word_t                   cfg_rdata;

	// checker side
	logic  go;
	logic  done;
	logic  is_send;
	logic  is_read;
	logic  exp_valid;
	word_t expected;
	int    idx;
	int    div;
	int    fail_count;
	int    test_count;

	entry_t table_q[$];
	integer seed;
	int     cur_div;
	int     limit;
	int     cycles = 0;

	uart_echo_top uart_echo_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.tx        (tx),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata)
	);

	uart_echo_checker uart_echo_checker_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.tx         (tx),
		.cfg_rdata  (cfg_rdata),
		.go         (go),
		.idx        (idx),
		.is_send    (is_send),
		.is_read    (is_read),
		.exp_valid  (exp_valid),
		.expected   (expected),
		.div        (div),
		.done       (done),
		.fail_count (fail_count),
		.test_count (test_count)
	);

	bind uart_echo_top uart_echo_assertions uart_echo_assertions_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx       (tx),
		.busy     (busy),
		.rx_valid (rx_valid),
		.tx_start (tx_start),
		.rx_frame (rx_frame)
	);

	// 20 ns period
	initial clk = 1'b0;
	always #10 clk = ~clk;

	////////////////////
	// run limit
	////////////////////

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: run still busy after %0d cycles", limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// send plus echo fits in 24 bit periods of the divisor in force
	function automatic int timeout_limit();
		int lim;
		int d;
		lim = 1000;
		d = 434;
		foreach (table_q[n]) begin
			lim += 24 * d;
			if (table_q[n].kind == WRITE && table_q[n].addr == uart_csr_pkg::CSR_DIV) begin
				d = int'(table_q[n].data);
			end
		end
		return lim;
	endfunction

	////////////////////
	// stimulus table
	////////////////////

	task automatic add_entry(input kind_t k, input uart_csr_pkg::csr_addr_t a,
			input word_t d, input logic ev, input word_t x);
		entry_t e;
		e.kind = k;
		e.addr = a;
		e.data = d;
		e.exp_valid = ev;
		e.expected = x;
		table_q.push_back(e);
	endtask

	// good byte, echoed back unchanged when echo_on
	task automatic add_byte(input uart_pkg::data_byte_t b, input logic echo_on);
		add_entry(SEND, uart_csr_pkg::CSR_DIV, word_t'(b), echo_on, word_t'(b));
	endtask

	task automatic build_table();
		uart_pkg::data_byte_t ref_bytes [11];
		logic [31:0]          rnd;
		int                   i;
		ref_bytes = '{8'h82, 8'hc2, "l", "l", "o", " ", "R", "S", "2", "3", "2"};
		// reset values
		add_entry(READ, uart_csr_pkg::CSR_DIV, '0, 1'b1, word_t'(434));
		add_entry(READ, uart_csr_pkg::CSR_CTRL, '0, 1'b1, word_t'(1));
		add_entry(READ, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, '0);
		add_entry(READ, uart_csr_pkg::CSR_FERR_COUNT, '0, 1'b1, '0);
		// reference bytes at 115200
		for (i = 0; i < 11; i++) begin
			add_byte(ref_bytes[i], 1'b1);
		end
		add_entry(READ, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, word_t'(11));
		// fast rate, random payload
		add_entry(WRITE, uart_csr_pkg::CSR_DIV, word_t'(32), 1'b1, word_t'(32));
		add_entry(READ, uart_csr_pkg::CSR_DIV, '0, 1'b1, word_t'(32));
		for (i = 0; i < 10; i++) begin
			rnd = $random(seed);
			add_byte(rnd[7:0], 1'b1);
		end
		// framing error, dropped and counted
		add_entry(SEND_BAD, uart_csr_pkg::CSR_DIV, word_t'(8'ha5), 1'b0, '0);
		add_entry(READ, uart_csr_pkg::CSR_FERR_COUNT, '0, 1'b1, word_t'(1));
		add_entry(READ, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, word_t'(21));
		add_byte(8'h5a, 1'b1);
		// echo off still counts
		add_entry(WRITE, uart_csr_pkg::CSR_CTRL, word_t'(0), 1'b1, '0);
		add_byte(8'h11, 1'b0);
		add_byte(8'h22, 1'b0);
		add_entry(READ, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, word_t'(24));
		add_entry(WRITE, uart_csr_pkg::CSR_CTRL, word_t'(1), 1'b1, word_t'(1));
		add_byte(8'h33, 1'b1);
		add_entry(READ, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, word_t'(25));
		// counter clears
		add_entry(WRITE, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, '0);
		add_entry(WRITE, uart_csr_pkg::CSR_FERR_COUNT, '0, 1'b1, '0);
		add_entry(READ, uart_csr_pkg::CSR_RX_COUNT, '0, 1'b1, '0);
		add_entry(READ, uart_csr_pkg::CSR_FERR_COUNT, '0, 1'b1, '0);
		add_entry(READ, uart_csr_pkg::CSR_CTRL, '0, 1'b1, word_t'(1));
	endtask

	////////////////////
	// serial peer and host
	////////////////////

	// 8N1 frame, one divisor of clocks per bit
	task automatic send_frame(input uart_pkg::data_byte_t b, input logic stop_bit);
		int i;
		rx = 1'b0;
		repeat (cur_div) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (cur_div) @(negedge clk);
		end
		rx = stop_bit;
		repeat (cur_div) @(negedge clk);
		rx = 1'b1;
	endtask

	task automatic write_reg(input word_t d);
		cfg_we = 1'b1;
		cfg_wdata = d;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic run_entry(input int n);
		entry_t e;
		e = table_q[n];
		@(negedge clk);
		idx = n;
		is_send = (e.kind == SEND || e.kind == SEND_BAD);
		is_read = (e.kind == READ);
		exp_valid = e.exp_valid;
		expected = e.expected;
		div = cur_div;
		cfg_addr = e.addr;
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		case (e.kind)
			SEND:     send_frame(e.data[7:0], 1'b1);
			SEND_BAD: send_frame(e.data[7:0], 1'b0);
			WRITE:    write_reg(e.data);
			default:  ;
		endcase
		while (!done) begin
			@(negedge clk);
		end
		// let the echo stop bit drain before the next row
		if (is_send) begin
			repeat (2 * cur_div) @(negedge clk);
		end
		if (e.kind == WRITE && e.addr == uart_csr_pkg::CSR_DIV) begin
			cur_div = int'(e.data);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		rx = 1'b1;
		cfg_we = 1'b0;
		cfg_addr = uart_csr_pkg::CSR_DIV;
		cfg_wdata = '0;
		go = 1'b0;
		idx = 0;
		is_send = 1'b0;
		is_read = 1'b0;
		exp_valid = 1'b0;
		expected = '0;
		cur_div = 434;
		div = cur_div;
		seed = 32'hdde46d53;
		build_table();
		limit = timeout_limit();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		foreach (table_q[n]) begin
			run_entry(n);
		end
		$display("%0d of %0d tests run, %0d failed", test_count, table_q.size(), fail_count);
		if (fail_count == 0 && test_count == table_q.size()) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+design
design/uart_pkg.sv
design/uart_csr_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_csr.sv
design/uart_echo_top.sv
tb/uart_echo_assertions.sv
tb/uart_echo_checker.sv
tb/tb_uart_echo.sv

//--- run.sh
#!/bin/sh
# build the echo testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module tb_uart_echo -Mdir obj_dir

if ! ./obj_dir/Vtb_uart_echo > sim.log 2>&1; then
	cat sim.log
	exit 1
fi
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
